// ==== src.f ====
hw/game_pkg.sv
hw/tile_pkg.sv
hw/tile_rules.sv
hw/move_interact.sv
hw/map_ram.sv
hw/player_ctrl.sv
hw/dungeon_top.sv
sim/dungeon_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u -o pipefail

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f src.f --top-module dungeon_tb -o dungeon_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/dungeon_sim 2>&1 | tee sim.log
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  echo "FAIL: failure reported in sim.log"
  exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
  echo "FAIL: no pass message in sim.log"
  exit 1
fi

echo "PASS"
exit 0

// ==== sim/dungeon_tb.sv ====
`default_nettype none

module dungeon_tb
  import game_pkg::*;
  import tile_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MOVE_TIMEOUT = 20;
  localparam int NUM_RANDOM   = 300;

  logic                  clk;
  logic                  rstn;
  logic                  move_req;
  logic [DIR_W-1:0]      move_dir;
  logic [COORD_W-1:0]    player_x;
  logic [COORD_W-1:0]    player_y;
  logic [KEY_W-1:0]      key_num;
  logic                  busy;
  logic                  move_done;
  logic                  host_we;
  logic [MAP_ADDR_W-1:0] host_addr;
  tile_word_t            host_wdata;
  tile_word_t            host_rdata;

  integer seed;

  // reference model state.
  logic [COORD_W-1:0] mx;
  logic [COORD_W-1:0] my;
  logic [KEY_W-1:0]   mkeys;
  logic [TILE_W-1:0]  mmap [MAP_WIDTH*MAP_HEIGHT];

  dungeon_top dut_i (
    .clk        (clk),
    .rstn       (rstn),
    .move_req   (move_req),
    .move_dir   (move_dir),
    .player_x   (player_x),
    .player_y   (player_y),
    .key_num    (key_num),
    .busy       (busy),
    .move_done  (move_done),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  always #10 clk = ~clk;

  task automatic check(input string name, input logic [15:0] got,
                       input logic [15:0] expected);
    if (got !== expected) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [15:0] data);
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(posedge clk);
    #2;
    host_we    = 1'b0;
    mmap[addr] = data;
  endtask

  // read port is registered, data one edge later.
  task automatic host_read_check(input logic [7:0] addr);
    host_addr = addr;
    @(posedge clk);
    #2;
    check("host_rdata", host_rdata, mmap[addr]);
  endtask

  task automatic random_tile(output logic [15:0] w);
    logic [31:0] r;
    r = $random(seed);
    case (r[3:0])
      4'd6, 4'd7:   w = {TILE_WALL, r[15:4]};
      4'd8, 4'd9:   w = {TILE_KEY, r[15:4]};
      4'd10, 4'd11: w = {TILE_DOOR, 2'b00, r[5:4], r[15:8]};
      4'd12:        w = {TILE_TELEPORT, r[15:4]};
      // a kind code with no meaning.
      4'd13:        w = {4'd9, r[15:4]};
      default:      w = {TILE_FLOOR, 12'd0};
    endcase
  endtask

  // one step of the game rules on the model copy.
  task automatic model_step(input logic [1:0] dir, output logic req,
                            output logic [7:0] addr);
    logic [3:0]  ax;
    logic [3:0]  ay;
    logic [15:0] t;
    ax  = mx;
    ay  = my;
    req = 1'b1;
    case (dir)
      DIR_UP: begin
        req = (my != 4'd0);
        ay  = my - 4'd1;
      end
      DIR_DOWN: begin
        req = (my != 4'd15);
        ay  = my + 4'd1;
      end
      DIR_LEFT: begin
        req = (mx != 4'd0);
        ax  = mx - 4'd1;
      end
      default: begin
        req = (mx != 4'd15);
        ax  = mx + 4'd1;
      end
    endcase
    addr = {ay, ax};
    if (req) begin
      t = mmap[addr];
      case (t[15:12])
        TILE_FLOOR: begin
          mx = ax;
          my = ay;
        end
        TILE_KEY: begin
          mx = ax;
          my = ay;
          if (mkeys != 4'd15) mkeys = mkeys + 4'd1;
          mmap[addr] = 16'h0000;
        end
        TILE_DOOR: begin
          if (mkeys >= t[11:8]) begin
            mx         = ax;
            my         = ay;
            mkeys      = mkeys - t[11:8];
            mmap[addr] = 16'h0000;
          end
        end
        TILE_TELEPORT: begin
          mx = t[11:8];
          my = t[7:4];
        end
        default: ;
      endcase
    end
  endtask

  // extra holds a second request up for the whole move.
  task automatic do_move(input logic [1:0] dir, input logic extra);
    logic        req;
    logic [7:0]  addr;
    logic [31:0] r;
    int          cycles;
    int          done_cnt;
    model_step(dir, req, addr);
    move_req = 1'b1;
    move_dir = dir;
    @(posedge clk);
    #2;
    move_req = 1'b0;
    if (!req) begin
      check("busy", 16'(busy), 16'd0);
    end else begin
      check("busy", 16'(busy), 16'd1);
      if (extra) begin
        r        = $random(seed);
        move_req = 1'b1;
        move_dir = r[1:0];
      end
      cycles   = 0;
      done_cnt = 0;
      while (busy) begin
        @(posedge clk);
        #2;
        if (move_done) done_cnt++;
        cycles++;
        if (cycles > MOVE_TIMEOUT) begin
          $display("timeout: the move to tile %0h never finished", addr);
          $display("Simulation failed");
          $fatal(1);
        end
      end
      move_req = 1'b0;
      check("move_done pulses", 16'(done_cnt), 16'd1);
    end
    check("player_x", 16'(player_x), 16'(mx));
    check("player_y", 16'(player_y), 16'(my));
    check("key_num", 16'(key_num), 16'(mkeys));
    if (req) host_read_check(addr);
  endtask

  initial begin
    logic [15:0] w;
    logic [31:0] r;
    seed       = 32'h33e5_2834;
    clk        = 1'b0;
    rstn       = 1'b0;
    move_req   = 1'b0;
    move_dir   = DIR_UP;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = TILE_FLOOR_WORD;
    mx         = START_X;
    my         = START_Y;
    mkeys      = '0;

    repeat (16) @(posedge clk);
    #2;
    rstn = 1'b1;
    check("busy", 16'(busy), 16'd0);
    check("move_done", 16'(move_done), 16'd0);
    check("player_x", 16'(player_x), 16'(START_X));
    check("player_y", 16'(player_y), 16'(START_Y));
    check("key_num", 16'(key_num), 16'd0);

    // random map, start tile kept as floor.
    for (int a = 0; a < MAP_WIDTH * MAP_HEIGHT; a++) begin
      random_tile(w);
      if (a == 0) w = 16'h0000;
      host_write(a[7:0], w);
    end

    // two keys, a door needing three, a key below, a teleport to (7,9).
    host_write(8'h01, 16'h2000);
    host_write(8'h02, 16'h2000);
    host_write(8'h03, 16'h3300);
    host_write(8'h12, 16'h2000);
    host_write(8'h04, 16'h4790);
    host_read_check(8'h03);

    // off the map from the corner.
    do_move(DIR_UP, 1'b0);
    do_move(DIR_LEFT, 1'b0);

    do_move(DIR_RIGHT, 1'b1);
    do_move(DIR_RIGHT, 1'b0);
    // door stays shut with two keys.
    do_move(DIR_RIGHT, 1'b0);
    do_move(DIR_DOWN, 1'b1);
    do_move(DIR_UP, 1'b0);
    do_move(DIR_RIGHT, 1'b0);
    do_move(DIR_RIGHT, 1'b0);
    check("player_x", 16'(player_x), 16'd7);
    check("player_y", 16'(player_y), 16'd9);

    // enough keys to reach the limit.
    for (int x = 8; x < 16; x++) begin
      host_write({4'd9, x[3:0]}, 16'h2000);
    end
    for (int x = 0; x < 16; x++) begin
      host_write({4'd10, x[3:0]}, 16'h2000);
    end
    for (int i = 0; i < 8; i++) begin
      do_move(DIR_RIGHT, 1'b0);
    end
    do_move(DIR_DOWN, 1'b0);
    for (int i = 0; i < 15; i++) begin
      do_move(DIR_LEFT, 1'b0);
    end
    check("key_num", 16'(key_num), 16'(KEY_MAX));

    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      do_move(r[1:0], r[4:2] == 3'd0);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/dungeon_top.sv ====
`default_nettype none

module dungeon_top
  import game_pkg::*;
  import tile_pkg::*;
(
  input  wire                  clk,
  input  wire                  rstn,

  input  wire                  move_req,
  input  wire [DIR_W-1:0]      move_dir,

  output logic [COORD_W-1:0]   player_x,
  output logic [COORD_W-1:0]   player_y,
  output logic [KEY_W-1:0]     key_num,
  output logic                 busy,
  output logic                 move_done,

  input  wire                  host_we,
  input  wire [MAP_ADDR_W-1:0] host_addr,
  input  wire tile_word_t      host_wdata,
  output tile_word_t           host_rdata
);

  logic                  player_ask_move;
  logic [COORD_W-1:0]    player_ask_x;
  logic [COORD_W-1:0]    player_ask_y;
  logic                  accept_move;
  logic [COORD_W-1:0]    goto_x;
  logic [COORD_W-1:0]    goto_y;
  logic [KEY_W-1:0]      key_num_out;
  logic [MAP_ADDR_W-1:0] map_addr;
  logic                  map_we;
  tile_word_t            map_wdata;
  tile_word_t            map_rdata;

  player_ctrl u_player_ctrl (
    .clk             (clk),
    .rstn            (rstn),
    .move_req        (move_req),
    .move_dir        (move_dir),
    .accept_move     (accept_move),
    .goto_x          (goto_x),
    .goto_y          (goto_y),
    .key_num_out     (key_num_out),
    .player_x        (player_x),
    .player_y        (player_y),
    .key_num         (key_num),
    .player_ask_move (player_ask_move),
    .player_ask_x    (player_ask_x),
    .player_ask_y    (player_ask_y),
    .busy            (busy)
  );

  move_interact u_move_interact (
    .clk             (clk),
    .rstn            (rstn),
    .player_x        (player_x),
    .player_y        (player_y),
    .key_num         (key_num),
    .player_ask_move (player_ask_move),
    .player_ask_x    (player_ask_x),
    .player_ask_y    (player_ask_y),
    .map_addr        (map_addr),
    .map_rdata       (map_rdata),
    .map_we          (map_we),
    .map_wdata       (map_wdata),
    .accept_move     (accept_move),
    .goto_x          (goto_x),
    .goto_y          (goto_y),
    .key_num_out     (key_num_out)
  );

  map_ram u_map_ram (
    .clk        (clk),
    .map_addr   (map_addr),
    .map_we     (map_we),
    .map_wdata  (map_wdata),
    .map_rdata  (map_rdata),
    .host_addr  (host_addr),
    .host_we    (host_we),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  // a move finishes with the accept pulse.
  assign move_done = accept_move;

endmodule

`default_nettype wire

// ==== hw/player_ctrl.sv ====
`default_nettype none

module player_ctrl
  import game_pkg::*;
(
  input  wire                clk,
  input  wire                rstn,

  input  wire                move_req,
  input  wire [DIR_W-1:0]    move_dir,

  input  wire                accept_move,
  input  wire [COORD_W-1:0]  goto_x,
  input  wire [COORD_W-1:0]  goto_y,
  input  wire [KEY_W-1:0]    key_num_out,

  output logic [COORD_W-1:0] player_x,
  output logic [COORD_W-1:0] player_y,
  output logic [KEY_W-1:0]   key_num,

  output logic               player_ask_move,
  output logic [COORD_W-1:0] player_ask_x,
  output logic [COORD_W-1:0] player_ask_y,

  output logic               busy
);

  logic [COORD_W-1:0] next_x;
  logic [COORD_W-1:0] next_y;
  logic               step_ok;
  logic               launch;

  // neighbour tile and edge check.
  always_comb begin
    next_x  = player_x;
    next_y  = player_y;
    step_ok = 1'b0;
    case (move_dir)
      DIR_UP: begin
        next_y  = player_y - 1'b1;
        step_ok = (player_y != '0);
      end
      DIR_DOWN: begin
        next_y  = player_y + 1'b1;
        step_ok = (player_y != COORD_W'(MAP_HEIGHT - 1));
      end
      DIR_LEFT: begin
        next_x  = player_x - 1'b1;
        step_ok = (player_x != '0);
      end
      DIR_RIGHT: begin
        next_x  = player_x + 1'b1;
        step_ok = (player_x != COORD_W'(MAP_WIDTH - 1));
      end
      default: step_ok = 1'b0;
    endcase
  end

  // requests while busy are dropped.
  assign launch = !busy && move_req && step_ok;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy            <= 1'b0;
      player_ask_move <= 1'b0;
      player_x        <= START_X;
      player_y        <= START_Y;
      key_num         <= '0;
    end else begin
      player_ask_move <= launch;
      if (launch) begin
        busy <= 1'b1;
      end else if (busy && accept_move) begin
        busy     <= 1'b0;
        player_x <= goto_x;
        player_y <= goto_y;
        key_num  <= key_num_out;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      player_ask_x <= next_x;
      player_ask_y <= next_y;
    end
  end

endmodule

`default_nettype wire

// ==== hw/map_ram.sv ====
`default_nettype none

module map_ram
  import game_pkg::*;
  import tile_pkg::*;
(
  input  wire                  clk,

  // interaction side.
  input  wire [MAP_ADDR_W-1:0] map_addr,
  input  wire                  map_we,
  input  wire tile_word_t      map_wdata,
  output tile_word_t           map_rdata,

  // host side.
  input  wire [MAP_ADDR_W-1:0] host_addr,
  input  wire                  host_we,
  input  wire tile_word_t      host_wdata,
  output tile_word_t           host_rdata
);

  tile_word_t mem [MAP_WIDTH*MAP_HEIGHT];

  // both write ports share one process.
  always_ff @(posedge clk) begin
    if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
    if (map_we) begin
      mem[map_addr] <= map_wdata;
    end
  end

  // host read is registered, one cycle latency.
  always_ff @(posedge clk) begin
    host_rdata <= mem[host_addr];
  end

  // address on port a is already registered upstream.
  assign map_rdata = mem[map_addr];

endmodule

`default_nettype wire

// ==== hw/move_interact.sv ====
`default_nettype none

module move_interact
  import game_pkg::*;
  import tile_pkg::*;
(
  input  wire                   clk,
  input  wire                   rstn,

  input  wire [COORD_W-1:0]     player_x,
  input  wire [COORD_W-1:0]     player_y,
  input  wire [KEY_W-1:0]       key_num,

  input  wire                   player_ask_move,
  input  wire [COORD_W-1:0]     player_ask_x,
  input  wire [COORD_W-1:0]     player_ask_y,

  output logic [MAP_ADDR_W-1:0] map_addr,
  input  wire tile_word_t       map_rdata,
  output logic                  map_we,
  output tile_word_t            map_wdata,

  output logic                  accept_move,
  output logic [COORD_W-1:0]    goto_x,
  output logic [COORD_W-1:0]    goto_y,
  output logic [KEY_W-1:0]      key_num_out
);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_LOADING  = 2'd1;
  localparam logic [1:0] ST_INTERACT = 2'd2;

  logic [1:0]         state;
  tile_word_t         tile_q;
  logic [COORD_W-1:0] ask_x;
  logic [COORD_W-1:0] ask_y;
  logic [COORD_W-1:0] rule_x;
  logic [COORD_W-1:0] rule_y;
  logic [KEY_W-1:0]   rule_keys;
  logic               rule_consume;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:     if (player_ask_move) state <= ST_LOADING;
        ST_LOADING:  state <= ST_INTERACT;
        ST_INTERACT: state <= ST_IDLE;
        default:     state <= ST_IDLE;
      endcase
    end
  end

  // y in the high nibble, x in the low one.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      map_addr <= '0;
    end else if (state == ST_IDLE && player_ask_move) begin
      map_addr <= {player_ask_y, player_ask_x};
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_LOADING) begin
      tile_q <= map_rdata;
    end
  end

  // asked tile, recovered from the held address.
  assign ask_x = map_addr[COORD_W-1:0];
  assign ask_y = map_addr[MAP_ADDR_W-1:COORD_W];

  tile_rules u_tile_rules (
    .tile        (tile_q),
    .ask_x       (ask_x),
    .ask_y       (ask_y),
    .player_x    (player_x),
    .player_y    (player_y),
    .key_num     (key_num),
    .goto_x      (rule_x),
    .goto_y      (rule_y),
    .key_num_out (rule_keys),
    .consume     (rule_consume)
  );

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      accept_move <= 1'b0;
      map_we      <= 1'b0;
    end else begin
      accept_move <= (state == ST_INTERACT);
      map_we      <= (state == ST_INTERACT) && rule_consume;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_INTERACT) begin
      goto_x      <= rule_x;
      goto_y      <= rule_y;
      key_num_out <= rule_keys;
    end
  end

  // consumed tiles turn into floor.
  assign map_wdata = TILE_FLOOR_WORD;

endmodule

`default_nettype wire

// ==== hw/tile_rules.sv ====
`default_nettype none

module tile_rules
  import game_pkg::*;
  import tile_pkg::*;
(
  input  wire tile_word_t     tile,
  input  wire [COORD_W-1:0]   ask_x,
  input  wire [COORD_W-1:0]   ask_y,
  input  wire [COORD_W-1:0]   player_x,
  input  wire [COORD_W-1:0]   player_y,
  input  wire [KEY_W-1:0]     key_num,
  output logic [COORD_W-1:0]  goto_x,
  output logic [COORD_W-1:0]  goto_y,
  output logic [KEY_W-1:0]    key_num_out,
  output logic                consume
);

  logic [KEY_W-1:0] key_inc;
  logic [KEY_W-1:0] key_need;
  logic             door_open;

  assign key_inc   = (key_num == KEY_MAX) ? key_num : key_num + 1'b1;
  assign key_need  = tile.arg.door_view.keys_needed;
  assign door_open = (key_num >= key_need);

  always_comb begin
    // default is to stay put.
    goto_x      = player_x;
    goto_y      = player_y;
    key_num_out = key_num;
    consume     = 1'b0;
    case (tile.kind)
      TILE_FLOOR: begin
        goto_x = ask_x;
        goto_y = ask_y;
      end
      TILE_KEY: begin
        goto_x      = ask_x;
        goto_y      = ask_y;
        key_num_out = key_inc;
        consume     = 1'b1;
      end
      TILE_DOOR: begin
        if (door_open) begin
          goto_x      = ask_x;
          goto_y      = ask_y;
          key_num_out = key_num - key_need;
          consume     = 1'b1;
        end
      end
      TILE_TELEPORT: begin
        goto_x = tile.arg.port_view.dest_x;
        goto_y = tile.arg.port_view.dest_y;
      end
      // wall and unknown kinds.
      default: begin
        goto_x = player_x;
        goto_y = player_y;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/tile_pkg.sv ====
`default_nettype none

package tile_pkg;
  import game_pkg::*;

  localparam int TILE_W      = 16;
  localparam int TILE_KIND_W = 4;
  localparam int TILE_ARG_W  = TILE_W - TILE_KIND_W;

  // kind codes, other values act as wall.
  localparam logic [TILE_KIND_W-1:0] TILE_FLOOR    = 4'd0;
  localparam logic [TILE_KIND_W-1:0] TILE_WALL     = 4'd1;
  localparam logic [TILE_KIND_W-1:0] TILE_KEY      = 4'd2;
  localparam logic [TILE_KIND_W-1:0] TILE_DOOR     = 4'd3;
  localparam logic [TILE_KIND_W-1:0] TILE_TELEPORT = 4'd4;

  typedef struct packed {
    logic [KEY_W-1:0]            keys_needed;
    logic [TILE_ARG_W-KEY_W-1:0] unused;
  } door_view_t;

  typedef struct packed {
    logic [COORD_W-1:0]              dest_x;
    logic [COORD_W-1:0]              dest_y;
    logic [TILE_ARG_W-2*COORD_W-1:0] unused;
  } port_view_t;

  // low field, read as door need or teleport target.
  typedef union packed {
    door_view_t door_view;
    port_view_t port_view;
  } tile_arg_u;

  typedef struct packed {
    logic [TILE_KIND_W-1:0] kind;
    tile_arg_u              arg;
  } tile_word_t;

  localparam tile_word_t TILE_FLOOR_WORD = '0;

endpackage

`default_nettype wire

// ==== hw/game_pkg.sv ====
`default_nettype none

package game_pkg;

  // map geometry.
  localparam int MAP_WIDTH  = 16;
  localparam int MAP_HEIGHT = 16;

  localparam int COORD_W    = 4;
  // address is y * MAP_WIDTH + x.
  localparam int MAP_ADDR_W = 8;

  // key counter, saturating.
  localparam int KEY_W = 4;
  localparam logic [KEY_W-1:0] KEY_MAX = 4'd15;

  // direction codes, up decreases y.
  localparam int DIR_W = 2;
  localparam logic [DIR_W-1:0] DIR_UP    = 2'd0;
  localparam logic [DIR_W-1:0] DIR_DOWN  = 2'd1;
  localparam logic [DIR_W-1:0] DIR_LEFT  = 2'd2;
  localparam logic [DIR_W-1:0] DIR_RIGHT = 2'd3;

  // position after reset.
  localparam logic [COORD_W-1:0] START_X = 4'd0;
  localparam logic [COORD_W-1:0] START_Y = 4'd0;

endpackage

`default_nettype wire
